// File: common/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// **************************************************
// Build-time UART configuration
// **************************************************

`define UART_SYSCLK_HZ   10000000   // SysClk rate
`define UART_BAUD        62500      // Line rate, 16x oversampled
`define UART_DATA_BITS   8          // Data bits per frame
`define UART_STOP_BITS   1          // 1 or 2

// Receive FIFO entries, power of two
`define UART_FIFO_DEPTH  8

// Holding queue size = host credits after reset
`define UART_TX_CREDITS  2

`define UART_BIST_LEN    4          // Bytes per self test
`define UART_BIST_SEED   8'hA5      // First BIST byte

`endif

// File: common/uartFramePkg.sv
`default_nettype none

// Serial frame side types
package uartFramePkg;

`include "uart_settings.svh"

	// One data word on the line
	typedef logic [`UART_DATA_BITS-1:0] dataT;

	typedef logic [3:0] bitIdxT;     // Data bit index within a frame
	typedef logic [15:0] tickCntT;   // Baud divisor counter

	// Transmitter FSM
	typedef enum logic [1:0] {
		txIdle, txStart, txData, txStop
	} txStateE;

	// Receiver FSM
	typedef enum logic [1:0] {
		rxIdle, rxStart, rxData, rxStop
	} rxStateE;

	// Self test controller
	typedef enum logic [1:0] {
		bistIdle, bistRun
	} bistStateE;

endpackage

`default_nettype wire

// File: common/uartHostPkg.sv
`default_nettype none

// Host side bundles
package uartHostPkg;

`include "uart_settings.svh"

	// Transmit word from host or BIST, spends one credit
	typedef struct packed {
		logic valid;
		uartFramePkg::dataT data;
	} txReqT;

	// Received byte, valid for one cycle
	typedef struct packed {
		logic valid;
		uartFramePkg::dataT data;
	} rxWordT;

	// Host visible status bits
	typedef struct packed {
		logic fifoEmpty;
		logic fifoFull;
		logic fifoOverflow;     // Sticky until reset
		logic txBusy;
		logic bistBusy;
		logic bistError;
	} statusT;

	// Occupancy needs one bit above the index width
	typedef logic [$clog2(`UART_FIFO_DEPTH):0] fifoCntT;

endpackage

`default_nettype wire

// File: verilog/baudTickGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

// 16x oversampling tick from SysClk
module baudTickGen (
	input  wire  SysClk,
	input  wire  arstN,
	output logic tick
);

	// SysClk cycles per oversample tick
	localparam int Divisor = `UART_SYSCLK_HZ / (`UART_BAUD * 16);
	localparam uartFramePkg::tickCntT LastCnt = uartFramePkg::tickCntT'(Divisor - 1);

	uartFramePkg::tickCntT divCnt;

	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			divCnt <= '0;
			tick   <= 1'b0;
		end else if (divCnt == LastCnt) begin
			divCnt <= '0;           // Wrap, one tick
			tick   <= 1'b1;
		end else begin
			divCnt <= divCnt + 1'b1;
			tick   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: uart/uartTx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

// Credit managed holding queue feeding the serial shifter
module uartTx (
	input  wire                 SysClk,
	input  wire                 arstN,
	input  wire                 tick,
	input  uartHostPkg::txReqT  txReq,
	input  wire                 cts,
	output logic                txCredit,
	output logic                txBusy,
	output logic                txLine
);

	localparam int QDepth = `UART_TX_CREDITS;   // Power of two, pointers wrap
	localparam int PtrW   = $clog2(QDepth);
	localparam int OccW   = $clog2(QDepth + 1);

	// **************************************************
	// Holding queue
	// **************************************************
	uartFramePkg::dataT  queue [QDepth];
	logic [PtrW-1:0]     wrPtr, rdPtr;
	logic [OccW-1:0]     occ;
	logic                doLoad;

	uartFramePkg::txStateE state;
	uartFramePkg::dataT    shReg;       // LSB goes out next
	uartFramePkg::bitIdxT  bitIdx;
	logic [1:0]            stopIdx;
	logic [3:0]            ovsCnt;      // Free running tick phase
	logic                  bitEnd;

	// Pull a byte only with the shifter empty and the far end ready
	assign doLoad = (state == uartFramePkg::txIdle) && !txBusy && (occ != '0) && cts;
	assign bitEnd = tick && (ovsCnt == 4'hF);   // 16-tick boundary

	always_ff @(posedge SysClk) begin
		if (txReq.valid)
			queue[wrPtr] <= txReq.data;
	end

	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			occ      <= '0;
			txCredit <= 1'b0;
		end else begin
			if (txReq.valid) wrPtr <= wrPtr + 1'b1;
			if (doLoad) rdPtr <= rdPtr + 1'b1;
			case ({txReq.valid, doLoad})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
			txCredit <= doLoad;     // Credit back one cycle after load
		end
	end

	// **************************************************
	// Frame shifter
	// **************************************************
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			state   <= uartFramePkg::txIdle;
			ovsCnt  <= '0;
			bitIdx  <= '0;
			stopIdx <= '0;
			txBusy  <= 1'b0;
			txLine  <= 1'b1;        // Idle high
		end else begin
			if (tick) ovsCnt <= ovsCnt + 1'b1;
			if (doLoad) txBusy <= 1'b1;
			case (state)
				uartFramePkg::txIdle:
					if (txBusy && bitEnd) begin
						state  <= uartFramePkg::txStart;
						txLine <= 1'b0;  // Start bit
					end
				uartFramePkg::txStart:
					if (bitEnd) begin
						state  <= uartFramePkg::txData;
						bitIdx <= '0;
						txLine <= shReg[0];
					end
				uartFramePkg::txData:
					if (bitEnd) begin
						if (bitIdx == uartFramePkg::bitIdxT'(`UART_DATA_BITS - 1)) begin
							state   <= uartFramePkg::txStop;
							stopIdx <= '0;
							txLine  <= 1'b1;
						end else begin
							bitIdx <= bitIdx + 1'b1;
							txLine <= shReg[1];  // Next bit, shReg moves below
						end
					end
				uartFramePkg::txStop:
					if (bitEnd) begin
						if (stopIdx == 2'(`UART_STOP_BITS - 1)) begin
							state  <= uartFramePkg::txIdle;
							txBusy <= 1'b0;      // End of last stop bit
						end else
							stopIdx <= stopIdx + 1'b1;
					end
				default: state <= uartFramePkg::txIdle;
			endcase
		end
	end

	// Payload shift, no reset needed
	always_ff @(posedge SysClk) begin
		if (doLoad)
			shReg <= queue[rdPtr];
		else if (bitEnd && (state == uartFramePkg::txData))
			shReg <= shReg >> 1;
	end

	noQueueOverrun : assert property (@(posedge SysClk) disable iff (!arstN)
		txReq.valid |-> (occ < OccW'(QDepth)))
		else $error("uartTx: write with no credit, queue full");

	idleLineHigh : assert property (@(posedge SysClk) disable iff (!arstN)
		(state == uartFramePkg::txIdle) |-> txLine)
		else $error("uartTx: line low while idle");

endmodule

`default_nettype wire

// File: uart/uartRx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

// Start detect, mid-bit sampling, stop check
module uartRx (
	input  wire                  SysClk,
	input  wire                  arstN,
	input  wire                  tick,
	input  wire                  rxLine,
	output uartHostPkg::rxWordT  rxWord,
	output logic                 rxError
);

	logic [1:0] rxSync;     // Two flop synchronizer
	logic       rxPrev;     // Edge history
	logic       lineS;
	logic       fallEdge;

	uartFramePkg::rxStateE state;
	uartFramePkg::dataT    shReg;
	uartFramePkg::bitIdxT  bitIdx;
	logic [1:0]            stopIdx;
	logic [3:0]            ovsCnt;
	logic                  midStart;   // 8th tick into start bit
	logic                  midBit;     // 16 ticks on from last sample

	assign lineS    = rxSync[1];
	assign fallEdge = rxPrev && !lineS;
	assign midStart = tick && (ovsCnt == 4'd7);
	assign midBit   = tick && (ovsCnt == 4'hF);

	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			rxSync <= 2'b11;        // Line idles high
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rxLine};
			rxPrev <= lineS;
		end
	end

	// **************************************************
	// Receive FSM
	// **************************************************
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			state   <= uartFramePkg::rxIdle;
			ovsCnt  <= '0;
			bitIdx  <= '0;
			stopIdx <= '0;
			rxWord  <= '0;
			rxError <= 1'b0;
		end else begin
			rxWord.valid <= 1'b0;   // Pulses by default low
			rxError      <= 1'b0;
			if (tick) ovsCnt <= ovsCnt + 1'b1;
			case (state)
				uartFramePkg::rxIdle:
					if (fallEdge) begin
						state  <= uartFramePkg::rxStart;
						ovsCnt <= '0;    // Phase locks to the edge
					end
				uartFramePkg::rxStart:
					if (midStart) begin
						ovsCnt <= '0;
						if (lineS)
							state <= uartFramePkg::rxIdle;   // Glitch, not a start
						else begin
							state  <= uartFramePkg::rxData;
							bitIdx <= '0;
						end
					end
				uartFramePkg::rxData:
					if (midBit) begin
						if (bitIdx == uartFramePkg::bitIdxT'(`UART_DATA_BITS - 1)) begin
							state   <= uartFramePkg::rxStop;
							stopIdx <= '0;
						end else
							bitIdx <= bitIdx + 1'b1;
					end
				uartFramePkg::rxStop:
					if (midBit) begin
						if (!lineS) begin
							rxError <= 1'b1;         // Framing error, byte dropped
							state   <= uartFramePkg::rxIdle;
						end else begin
							// Byte goes out after the first good stop
							if (stopIdx == 2'd0)
								rxWord <= '{valid: 1'b1, data: shReg};
							if (stopIdx == 2'(`UART_STOP_BITS - 1))
								state <= uartFramePkg::rxIdle;
							else
								stopIdx <= stopIdx + 1'b1;
						end
					end
				default: state <= uartFramePkg::rxIdle;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge SysClk) begin
		if ((state == uartFramePkg::rxData) && midBit)
			shReg <= {lineS, shReg[`UART_DATA_BITS-1:1]};
	end

	validXorError : assert property (@(posedge SysClk) disable iff (!arstN)
		!(rxWord.valid && rxError))
		else $error("uartRx: byte and framing error in the same cycle");

endmodule

`default_nettype wire

// File: verilog/rxFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

// Receive FIFO, host pops the oldest entry
module rxFifo (
	input  wire                   SysClk,
	input  wire                   arstN,
	input  uartHostPkg::rxWordT   wrWord,
	input  wire                   pop,
	output uartFramePkg::dataT    rdData,
	output uartHostPkg::fifoCntT  count,
	output logic                  fifoFull,
	output logic                  fifoEmpty,
	output logic                  fifoOverflow,
	output logic                  rts
);

	localparam int Depth = `UART_FIFO_DEPTH;
	localparam int PtrW  = $clog2(Depth);

	uartFramePkg::dataT   mem [Depth];
	logic [PtrW-1:0]      wrPtr, rdPtr;    // Natural wrap, depth is 2^n
	uartHostPkg::fifoCntT nextCnt;
	logic                 doWrite, doPop;

	assign doWrite = wrWord.valid && !fifoFull;  // Full drops the byte
	assign doPop   = pop && !fifoEmpty;          // Pop on empty ignored
	assign rdData  = mem[rdPtr];

	always_comb begin
		case ({doWrite, doPop})
			2'b10:   nextCnt = count + 1'b1;
			2'b01:   nextCnt = count - 1'b1;
			default: nextCnt = count;
		endcase
	end

	always_ff @(posedge SysClk) begin
		if (doWrite)
			mem[wrPtr] <= wrWord.data;
	end

	// Pointers and registered flags
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			fifoEmpty    <= 1'b1;
			fifoFull     <= 1'b0;
			fifoOverflow <= 1'b0;
			rts          <= 1'b1;
		end else begin
			if (doWrite) wrPtr <= wrPtr + 1'b1;
			if (doPop) rdPtr <= rdPtr + 1'b1;
			count     <= nextCnt;
			fifoEmpty <= (nextCnt == '0);
			fifoFull  <= (nextCnt == uartHostPkg::fifoCntT'(Depth));
			rts       <= (nextCnt != uartHostPkg::fifoCntT'(Depth));  // Low while full
			if (wrWord.valid && fifoFull)
				fifoOverflow <= 1'b1;   // Sticky
		end
	end

	countInRange : assert property (@(posedge SysClk) disable iff (!arstN)
		count <= uartHostPkg::fifoCntT'(Depth))
		else $error("rxFifo: occupancy above depth");

endmodule

`default_nettype wire

// File: verilog/selfTest.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

// BIST: loop TX into RX, send a rotating pattern, compare returns
module selfTest (
	input  wire                  SysClk,
	input  wire                  arstN,
	input  wire                  bistStart,
	input  wire                  txCredit,
	input  uartHostPkg::rxWordT  rxWord,
	output logic                 bistMode,
	output uartHostPkg::txReqT   bistReq,
	output logic                 bistBusy,
	output logic                 bistError
);

	localparam int Len     = `UART_BIST_LEN;
	localparam int CntW    = $clog2(Len + 1);
	localparam int CredW   = $clog2(`UART_TX_CREDITS + 1);
	localparam int FrameCy = (1 + `UART_DATA_BITS + `UART_STOP_BITS) * 16
		* (`UART_SYSCLK_HZ / (`UART_BAUD * 16));
	localparam int WdLimit = (Len + 2) * FrameCy;   // Two frames of slack
	localparam int WdW     = $clog2(WdLimit + 1);

	uartFramePkg::bistStateE state;
	uartFramePkg::dataT      txPat, rxPat;   // Send and expect generators
	logic [CntW-1:0]         sentCnt, rcvCnt;
	logic [CredW-1:0]        credits;
	logic [WdW-1:0]          wdCnt;
	logic                    doSend;

	function automatic uartFramePkg::dataT rotl(input uartFramePkg::dataT d);
		return {d[`UART_DATA_BITS-2:0], d[`UART_DATA_BITS-1]};
	endfunction

	// Same credit rule as the host
	assign doSend   = (state == uartFramePkg::bistRun) && (sentCnt != CntW'(Len))
		&& (credits != '0);
	assign bistBusy = (state != uartFramePkg::bistIdle);

	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			state     <= uartFramePkg::bistIdle;
			bistMode  <= 1'b0;
			bistError <= 1'b0;
			bistReq   <= '0;
			sentCnt   <= '0;
			rcvCnt    <= '0;
			credits   <= '0;
			wdCnt     <= '0;
			txPat     <= '0;
			rxPat     <= '0;
		end else begin
			bistReq <= '{valid: doSend, data: txPat};
			case (state)
				uartFramePkg::bistIdle:
					if (bistStart) begin
						state     <= uartFramePkg::bistRun;
						bistMode  <= 1'b1;      // Loopback on, pin held high
						bistError <= 1'b0;
						sentCnt   <= '0;
						rcvCnt    <= '0;
						credits   <= CredW'(`UART_TX_CREDITS);
						wdCnt     <= '0;
						txPat     <= `UART_BIST_SEED;
						rxPat     <= `UART_BIST_SEED;
					end
				uartFramePkg::bistRun: begin
					wdCnt <= wdCnt + 1'b1;
					case ({txCredit, doSend})
						2'b10:   credits <= credits + 1'b1;
						2'b01:   credits <= credits - 1'b1;
						default: credits <= credits;
					endcase
					if (doSend) begin
						sentCnt <= sentCnt + 1'b1;
						txPat   <= rotl(txPat);
					end
					if (rxWord.valid) begin
						if (rxWord.data != rxPat) bistError <= 1'b1;
						rxPat  <= rotl(rxPat);
						rcvCnt <= rcvCnt + 1'b1;
					end
					// Done on last return, or watchdog
					if (rxWord.valid && (rcvCnt == CntW'(Len - 1))) begin
						state    <= uartFramePkg::bistIdle;
						bistMode <= 1'b0;
					end else if (wdCnt == WdW'(WdLimit)) begin
						state     <= uartFramePkg::bistIdle;
						bistMode  <= 1'b0;
						bistError <= 1'b1;   // Bytes lost in the loop
					end
				end
				default: state <= uartFramePkg::bistIdle;
			endcase
		end
	end

	// Credits come back from uartTx, never more than handed out
	creditBound : assert property (@(posedge SysClk) disable iff (!arstN)
		credits <= CredW'(`UART_TX_CREDITS))
		else $error("selfTest: more credits returned than spent");

endmodule

`default_nettype wire

// File: verilog/uartTop.sv
`timescale 1ns/1ps
`default_nettype none

// UART subsystem top, pin controlled
module uartTop (
	input  wire                  SysClk,
	input  wire                  arstN,
	input  uartHostPkg::txReqT   txReq,
	output logic                 txCredit,
	input  wire                  cts,
	output logic                 tx,
	input  wire                  rx,
	output logic                 rts,
	input  wire                  pop,
	output uartFramePkg::dataT   rdData,
	output logic                 rxError,
	input  wire                  bistStart,
	output uartHostPkg::statusT  status
);

	logic                 tick;
	logic                 txLine, rxIn;      // Shifter out, receiver in
	logic                 txCreditInt, txBusy;
	logic                 bistMode, bistBusy, bistError;
	logic                 fifoFull, fifoEmpty, fifoOverflow;
	uartHostPkg::txReqT   bistReq, txSrc;
	uartHostPkg::rxWordT  rxWord, fifoWord, bistWord;

	// **************************************************
	// Loopback muxing and steering
	// **************************************************
	assign txSrc    = bistMode ? bistReq : txReq;
	assign rxIn     = bistMode ? txLine : rx;     // Internal loop in BIST
	assign tx       = bistMode ? 1'b1 : txLine;   // Pin isolated during BIST
	assign txCredit = txCreditInt && !bistMode;   // BIST keeps its own credits
	assign fifoWord = '{valid: rxWord.valid && !bistMode, data: rxWord.data};
	assign bistWord = '{valid: rxWord.valid && bistMode, data: rxWord.data};

	assign status = '{fifoEmpty: fifoEmpty, fifoFull: fifoFull,
		fifoOverflow: fifoOverflow, txBusy: txBusy,
		bistBusy: bistBusy, bistError: bistError};

	baudTickGen baudGen (.SysClk, .arstN, .tick);

	uartTx transmitter (.SysClk, .arstN, .tick, .txReq(txSrc), .cts,
		.txCredit(txCreditInt), .txBusy, .txLine);

	uartRx receiver (.SysClk, .arstN, .tick, .rxLine(rxIn), .rxWord, .rxError);

	rxFifo fifo (.SysClk, .arstN, .wrWord(fifoWord), .pop, .rdData,
		.count(), .fifoFull, .fifoEmpty, .fifoOverflow, .rts);

	selfTest bist (.SysClk, .arstN, .bistStart, .txCredit(txCreditInt),
		.rxWord(bistWord), .bistMode, .bistReq, .bistBusy, .bistError);

	noHostWriteInBist : assert property (@(posedge SysClk) disable iff (!arstN)
		status.bistBusy |-> !txReq.valid)
		else $error("uartTop: host write during self test");

endmodule

`default_nettype wire

// File: dv/uartTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

// Testbench for uartTop with serial line models and six directed tests
module uartTb;

	localparam int FrameBits   = 1 + `UART_DATA_BITS + `UART_STOP_BITS;
	localparam int BitCycles   = `UART_SYSCLK_HZ / `UART_BAUD;   // SysClk per bit
	localparam int FrameCycles = FrameBits * BitCycles;

	logic                SysClk;
	logic                arstN;
	uartHostPkg::txReqT  txReq;
	logic                txCredit;
	logic                cts;
	logic                tx;
	logic                rx;
	logic                rts;
	logic                pop;
	uartFramePkg::dataT  rdData;
	logic                rxError;
	logic                bistStart;
	uartHostPkg::statusT status;

	uartFramePkg::dataT txExpect[$];    // Host bytes still owed on tx
	uartFramePkg::dataT fifoModel[$];   // Receive FIFO model

	int errCnt      = 0;
	int checkCnt    = 0;
	int testsRun    = 0;
	int testsFailed = 0;
	int framesSeen  = 0;
	int creditsBack = 0;   // txCredit pulses seen
	int spent       = 0;   // Host writes issued
	int rxErrSeen   = 0;
	bit timedOut    = 1'b0;

	uartTop DUT (.SysClk, .arstN, .txReq, .txCredit, .cts, .tx, .rx, .rts, .pop,
		.rdData, .rxError, .bistStart, .status);

	always #50 SysClk = ~SysClk;   // 100 ns period

	// **************************************************
	// Reference models
	// **************************************************

	// Line bits of a frame, index 0 is the start bit
	function automatic logic [FrameBits-1:0] frameBits(input uartFramePkg::dataT d);
		return {{`UART_STOP_BITS{1'b1}}, d, 1'b0};
	endfunction

	// BIST byte n: seed rotated left n times
	function automatic uartFramePkg::dataT bistByte(input int n);
		uartFramePkg::dataT b;
		int k;
		b = `UART_BIST_SEED;
		for (k = 0; k < n; k++)
			b = {b[`UART_DATA_BITS-2:0], b[`UART_DATA_BITS-1]};
		return b;
	endfunction

	function automatic int heldCredits();
		return `UART_TX_CREDITS + creditsBack - spent;
	endfunction

	task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checkCnt++;
		if (got !== exp) begin
			$display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			errCnt++;
		end
	endtask

	task automatic timeoutHit(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		timedOut = 1'b1;
		errCnt++;
	endtask

	// Pulse counters, sampled mid cycle
	always @(negedge SysClk) begin
		if (arstN && txCredit) creditsBack++;
		if (arstN && rxError) rxErrSeen++;
	end

	// **************************************************
	// Serial line driver and decoder
	// **************************************************
	task automatic sendFrame(input uartFramePkg::dataT d, input logic stopVal);
		logic [FrameBits-1:0] bits;
		int i;
		bits = frameBits(d);
		bits[1 + `UART_DATA_BITS] = stopVal;   // First stop bit
		for (i = 0; i < FrameBits; i++) begin
			@(posedge SysClk);
			rx <= bits[i];
			repeat (BitCycles - 1) @(posedge SysClk);
		end
		@(posedge SysClk);
		rx <= 1'b1;
		repeat (16) @(posedge SysClk);   // Short idle gap
	endtask

	// Called on the first low sample, then samples at bit centers
	task automatic decodeFrame(output logic [FrameBits-1:0] bits);
		int i;
		repeat (BitCycles / 2) @(negedge SysClk);
		bits[0] = tx;
		for (i = 1; i < FrameBits; i++) begin
			repeat (BitCycles) @(negedge SysClk);
			bits[i] = tx;
		end
	endtask

	// Compares every frame on tx with the next expected host byte
	initial begin : frameMonitor
		logic [FrameBits-1:0] bits;
		forever begin
			@(negedge SysClk);
			if (arstN && tx === 1'b0) begin
				decodeFrame(bits);
				checkEq("txBusy during frame", status.txBusy, 1'b1);
				if (txExpect.size() == 0) begin
					$display("Unexpected frame on tx at %0t ns with no byte queued", $time);
					errCnt++;
				end else
					checkEq("tx frame bits", bits, frameBits(txExpect.pop_front()));
				framesSeen++;
			end
		end
	end

	// **************************************************
	// Host side helpers
	// **************************************************
	task automatic hostWrite(input uartFramePkg::dataT d);
		checkEq("credit held before write",
			heldCredits() > 0 && heldCredits() <= `UART_TX_CREDITS, 1'b1);
		@(posedge SysClk);
		txReq <= '{valid: 1'b1, data: d};
		txExpect.push_back(d);
		spent++;
		@(posedge SysClk);
		txReq <= '0;
	endtask

	task automatic waitCredit(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge SysClk);
			n++;
		end while (heldCredits() <= 0 && !timedOut && n < limit);
		if (heldCredits() <= 0 && !timedOut) timeoutHit("no transmit credit returned");
	endtask

	task automatic waitFrames(input int target, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge SysClk);
			n++;
		end while ((framesSeen < target || status.txBusy) && !timedOut && n < limit);
		if ((framesSeen < target || status.txBusy) && !timedOut)
			timeoutHit("expected frames never finished on tx");
	endtask

	task automatic waitNotEmpty(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge SysClk);
			n++;
		end while (status.fifoEmpty && !timedOut && n < limit);
		if (status.fifoEmpty && !timedOut) timeoutHit("receive FIFO stayed empty");
	endtask

	// Compare head with model, then pop one entry
	task automatic popCheck(input string what);
		waitNotEmpty(2 * FrameCycles);
		checkEq(what, rdData, fifoModel.pop_front());
		@(posedge SysClk);
		pop <= 1'b1;
		@(posedge SysClk);
		pop <= 1'b0;
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errCnt == errBefore)
			$display("Test %0d %s: ok", testsRun, name);
		else begin
			testsFailed++;
			$display("Test %0d %s: %0d errors", testsRun, name, errCnt - errBefore);
		end
	endtask

	// **************************************************
	// Tests
	// **************************************************
	task automatic testCreditTx();
		int i;
		int base;
		base = framesSeen;
		for (i = 0; i < 20; i++) begin
			waitCredit(4 * FrameCycles);
			hostWrite(uartFramePkg::dataT'($urandom));
		end
		waitFrames(base + 20, 22 * (FrameCycles + BitCycles));
		checkEq("all credits back", heldCredits(), `UART_TX_CREDITS);
	endtask

	task automatic testRxPath();
		int i;
		uartFramePkg::dataT d;
		for (i = 0; i < 8; i++) begin
			d = uartFramePkg::dataT'($urandom);
			sendFrame(d, 1'b1);
			fifoModel.push_back(d);
			if (i % 2 == 1) begin      // Drain in pairs
				popCheck("rx byte, first of pair");
				popCheck("rx byte, second of pair");
			end
		end
		@(negedge SysClk);
		checkEq("fifoEmpty after drain", status.fifoEmpty, 1'b1);
		checkEq("no overflow yet", status.fifoOverflow, 1'b0);
	endtask

	task automatic testOverflow();
		int i;
		uartFramePkg::dataT d;
		for (i = 0; i < `UART_FIFO_DEPTH + 2; i++) begin
			d = uartFramePkg::dataT'($urandom);
			sendFrame(d, 1'b1);
			if (i < `UART_FIFO_DEPTH) fifoModel.push_back(d);   // Extra bytes dropped
		end
		@(negedge SysClk);
		checkEq("fifoFull when full", status.fifoFull, 1'b1);
		checkEq("rts low when full", rts, 1'b0);
		checkEq("fifoOverflow set", status.fifoOverflow, 1'b1);
		for (i = 0; i < `UART_FIFO_DEPTH; i++)
			popCheck("overflow drain byte");
		@(negedge SysClk);
		checkEq("fifoEmpty after overflow drain", status.fifoEmpty, 1'b1);
		checkEq("rts back high", rts, 1'b1);
	endtask

	task automatic testFramingError();
		int errBase;
		uartFramePkg::dataT d;
		errBase = rxErrSeen;
		sendFrame(uartFramePkg::dataT'($urandom), 1'b0);
		@(negedge SysClk);
		checkEq("one rxError pulse", rxErrSeen - errBase, 1);
		checkEq("bad byte not stored", status.fifoEmpty, 1'b1);
		d = uartFramePkg::dataT'($urandom);
		sendFrame(d, 1'b1);
		fifoModel.push_back(d);
		popCheck("good byte after framing error");
	endtask

	task automatic testCtsStall();
		int base;
		int lowCnt;
		int n;
		base = framesSeen;
		lowCnt = 0;
		@(posedge SysClk);
		cts <= 1'b0;
		hostWrite(uartFramePkg::dataT'($urandom));
		for (n = 0; n < 3 * FrameCycles; n++) begin
			@(negedge SysClk);
			if (!tx) lowCnt++;
		end
		checkEq("tx idle while cts low", lowCnt, 0);
		checkEq("no frame while cts low", framesSeen, base);
		checkEq("txBusy low while stalled", status.txBusy, 1'b0);
		@(posedge SysClk);
		cts <= 1'b1;
		waitFrames(base + 1, 2 * FrameCycles);
		checkEq("credit back after stall", heldCredits(), `UART_TX_CREDITS);
	endtask

	task automatic testSelfTest();
		int n;
		int lowCnt;
		int idx;
		int base;
		base = framesSeen;
		lowCnt = 0;
		idx = 0;
		@(posedge SysClk);
		bistStart <= 1'b1;
		@(posedge SysClk);
		bistStart <= 1'b0;
		n = 0;
		do begin
			@(negedge SysClk);
			n++;
		end while (!status.bistBusy && !timedOut && n < 16);
		if (!status.bistBusy && !timedOut) timeoutHit("bistBusy never rose");
		n = 0;
		while (status.bistBusy && !timedOut) begin
			@(negedge SysClk);
			n++;
			if (!tx) lowCnt++;
			if (DUT.bistWord.valid) begin   // Looped byte into selfTest
				checkEq("BIST looped byte", DUT.bistWord.data, bistByte(idx));
				idx++;
			end
			if (n > (`UART_BIST_LEN + 4) * FrameCycles) timeoutHit("bistBusy never fell");
		end
		checkEq("bistError low", status.bistError, 1'b0);
		checkEq("BIST bytes returned", idx, `UART_BIST_LEN);
		checkEq("tx pin held high", lowCnt, 0);
		checkEq("no frames on tx pin", framesSeen, base);
		checkEq("FIFO still empty", status.fifoEmpty, 1'b1);
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial begin : mainSeq
		int errBefore;
		SysClk    = 1'b0;
		arstN     = 1'b0;
		txReq     = '0;
		cts       = 1'b1;
		rx        = 1'b1;   // Line idle
		pop       = 1'b0;
		bistStart = 1'b0;
		void'($urandom(63863));
		repeat (8) @(posedge SysClk);
		arstN <= 1'b1;
		@(negedge SysClk);
		checkEq("tx high after reset", tx, 1'b1);
		checkEq("rts high after reset", rts, 1'b1);
		checkEq("fifoEmpty after reset", status.fifoEmpty, 1'b1);
		checkEq("txBusy low after reset", status.txBusy, 1'b0);

		errBefore = errCnt;
		if (!timedOut) testCreditTx();
		reportTest("credit limited transmit", errBefore);
		errBefore = errCnt;
		if (!timedOut) testRxPath();
		reportTest("receive path", errBefore);
		errBefore = errCnt;
		if (!timedOut) testOverflow();
		reportTest("FIFO overflow", errBefore);
		errBefore = errCnt;
		if (!timedOut) testFramingError();
		reportTest("framing error", errBefore);
		errBefore = errCnt;
		if (!timedOut) testCtsStall();
		reportTest("CTS stall", errBefore);
		errBefore = errCnt;
		if (!timedOut) testSelfTest();
		reportTest("self test", errBefore);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCnt, errCnt);
		if (errCnt == 0 && !timedOut)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/uartFramePkg.sv
common/uartHostPkg.sv
verilog/baudTickGen.sv
uart/uartTx.sv
uart/uartRx.sv
verilog/rxFifo.sv
verilog/selfTest.sv
verilog/uartTop.sv
dv/uartTb.sv

// File: Makefile
# Verilator build and run of the UART testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f tb.f --top-module uartTb -o uartSim
	./obj_dir/uartSim | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
